// ==== design/udp_pkg.sv ====
/*
 * UDP datagram types and constants for the beacon source.
 * Holds the fixed header fields read by the stack integration,
 * the payload byte table and the destination host table.
 */
`default_nettype none

package udp_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [31:0] ipv4_addr_t;
    typedef logic [15:0] port_t;
    typedef logic [4:0]  payload_idx_t;
    typedef logic [1:0]  host_sel_t;

    localparam int PAYLOAD_LEN = 18;
    localparam int UDP_HDR_LEN = 8;

    // header plus payload, in bytes
    localparam port_t UDP_LENGTH = port_t'(UDP_HDR_LEN + PAYLOAD_LEN);

    localparam port_t      SRC_PORT  = 16'd1234;
    localparam port_t      DEST_PORT = 16'd5678;
    localparam byte_t      IP_TTL    = 8'd64;
    localparam ipv4_addr_t LOCAL_IP  = {8'd192, 8'd168, 8'd1, 8'd128};

    // message bytes, sent in index order
    localparam byte_t PAYLOAD_TABLE [PAYLOAD_LEN] = '{
        8'h41, 8'h42, 8'h43, 8'h44, 8'h45, 8'h46, 8'h47, 8'h48, 8'h49,
        8'h50, 8'h51, 8'h52, 8'h53, 8'h54, 8'h55, 8'h56, 8'h57, 8'h58
    };

    // destinations selected by host_sel
    localparam ipv4_addr_t HOST_TABLE [4] = '{
        {8'd192, 8'd168, 8'd1, 8'd100},
        {8'd192, 8'd168, 8'd1, 8'd101},
        {8'd192, 8'd168, 8'd1, 8'd102},
        {8'd192, 8'd168, 8'd1, 8'd103}
    };

endpackage

`default_nettype wire

// ==== design/panel_pkg.sv ====
/*
 * Front panel types: hex digit nibbles, active-low seven-segment
 * patterns and the green LED vector.
 */
`default_nettype none

package panel_pkg;

    // number of seven-segment displays on the board
    localparam int HEX_DIGITS = 8;

    typedef logic [3:0] nibble_t;

    // segment a in bit 0, a lit segment drives 0
    typedef logic [6:0] seg7_t;

    typedef logic [8:0] ledg_t;

endpackage

`default_nettype wire

// ==== design/payload_if.sv ====
/*
 * Payload byte stream with valid/ready handshake and end-of-frame flag.
 * A byte moves on an edge where valid and ready are both high.
 */
`timescale 1ns/100ps
`default_nettype none

interface payload_if;
    import udp_pkg::*;

    byte_t data;
    logic  valid;
    logic  last;
    logic  ready;

    // byte producer
    modport source (output data, output valid, output last, input ready);

    // passive observer
    modport monitor (input data, input valid, input last, input ready);

endinterface

`default_nettype wire

// ==== design/seg7_decoder.sv ====
/*
 * Hex digit to seven-segment pattern, active low, segment a in bit 0.
 */
`timescale 1ns/100ps
`default_nettype none

module seg7_decoder (
    input  wire panel_pkg::nibble_t digit,
    output panel_pkg::seg7_t        segments
);

    // patterns already inverted for common-anode displays
    always_comb begin
        case (digit)
            4'h0:    segments = 7'h40;
            4'h1:    segments = 7'h79;
            4'h2:    segments = 7'h24;
            4'h3:    segments = 7'h30;
            4'h4:    segments = 7'h19;
            4'h5:    segments = 7'h12;
            4'h6:    segments = 7'h02;
            4'h7:    segments = 7'h78;
            4'h8:    segments = 7'h00;
            4'h9:    segments = 7'h10;
            4'ha:    segments = 7'h08;
            // lower case b and d
            4'hb:    segments = 7'h03;
            4'hc:    segments = 7'h46;
            4'hd:    segments = 7'h21;
            4'he:    segments = 7'h06;
            default: segments = 7'h0e;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/send_ctrl.sv ====
/*
 * Send controller. A button press while armed latches the selected
 * destination and issues a one-cycle start strobe; after the frame it
 * waits for the button to be released before a new press is accepted.
 */
`timescale 1ns/100ps
`default_nettype none

module send_ctrl (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     btn_send,
    input  wire                     armed,
    input  wire udp_pkg::host_sel_t host_sel,
    input  wire                     done,
    output logic                    start,
    output udp_pkg::ipv4_addr_t     dest_ip
);
    import udp_pkg::*;

    typedef enum logic [1:0] {
        idle,
        streaming,
        await_release
    } state_t;

    state_t state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= idle;
            start   <= 1'b0;
            dest_ip <= '0;
        end else begin
            start <= 1'b0;
            case (state)
                idle: begin
                    if (btn_send && armed) begin
                        // destination held for the whole frame
                        dest_ip <= HOST_TABLE[host_sel];
                        start   <= 1'b1;
                        state   <= streaming;
                    end
                end
                streaming: begin
                    if (done) begin
                        state <= await_release;
                    end
                end
                await_release: begin
                    // one frame per press
                    if (!btn_send) begin
                        state <= idle;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/payload_source.sv ====
/*
 * Payload source. On start it presents the fixed message one byte at a
 * time on the stream, holding each byte until it is accepted, and
 * pulses done the cycle after the last byte moves.
 */
`timescale 1ns/100ps
`default_nettype none

module payload_source (
    input  wire        clk,
    input  wire        rst,
    input  wire        start,
    output logic       done,
    payload_if.source  stream
);
    import udp_pkg::*;

    localparam payload_idx_t LAST_IDX = payload_idx_t'(PAYLOAD_LEN - 1);

    payload_idx_t idx;
    payload_idx_t next_idx;
    byte_t        data_q;
    logic         valid_q;
    logic         last_q;
    logic         xfer;

    assign xfer     = valid_q && stream.ready;
    assign next_idx = idx + 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            idx     <= '0;
            valid_q <= 1'b0;
            last_q  <= 1'b0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                idx     <= '0;
                valid_q <= 1'b1;
                last_q  <= 1'b0;
            end else if (xfer) begin
                if (last_q) begin
                    valid_q <= 1'b0;
                    last_q  <= 1'b0;
                    done    <= 1'b1;
                end else begin
                    idx    <= next_idx;
                    last_q <= (next_idx == LAST_IDX);
                end
            end
        end
    end

    // byte register follows the index, holds while stalled
    always_ff @(posedge clk) begin
        if (start) begin
            data_q <= PAYLOAD_TABLE[0];
        end else if (xfer && !last_q) begin
            data_q <= PAYLOAD_TABLE[next_idx];
        end
    end

    assign stream.data  = data_q;
    assign stream.valid = valid_q;
    assign stream.last  = last_q;

endmodule

`default_nettype wire

// ==== design/front_panel.sv ====
/*
 * Front panel driver. Shows the first byte of the latest frame on the
 * green LEDs and the destination address on the hex displays, one
 * nibble per digit with digit 0 on the least significant nibble.
 */
`timescale 1ns/100ps
`default_nettype none

module front_panel (
    input  wire                      clk,
    input  wire                      rst,
    input  wire udp_pkg::ipv4_addr_t dest_ip,
    payload_if.monitor               stream,
    output panel_pkg::ledg_t         ledg,
    output panel_pkg::seg7_t         hex [panel_pkg::HEX_DIGITS]
);
    import panel_pkg::*;

    logic xfer;
    logic at_first;

    assign xfer = stream.valid && stream.ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            at_first <= 1'b1;
            ledg     <= '0;
        end else if (xfer) begin
            // next transfer opens a frame once last has gone by
            at_first <= stream.last;
            if (at_first) begin
                ledg <= ledg_t'(stream.data);
            end
        end
    end

    genvar k;
    for (k = 0; k < HEX_DIGITS; k++) begin : g_digit
        seg7_decoder u_dec (
            .digit    (dest_ip[$bits(nibble_t)*k +: $bits(nibble_t)]),
            .segments (hex[k])
        );
    end

endmodule

`default_nettype wire

// ==== design/udp_beacon_top.sv ====
/*
 * Push-button UDP beacon source. btn[0] sends the message while sw[0]
 * arms it, sw[2:1] pick the destination host. The header strobe, the
 * destination and the payload stream go to an external UDP stack.
 */
`timescale 1ns/100ps
`default_nettype none

module udp_beacon_top (
    input  wire                 clk,
    input  wire                 rst,
    input  wire [3:0]           btn,
    input  wire [17:0]          sw,
    input  wire                 tx_ready,
    output logic                hdr_valid,
    output udp_pkg::ipv4_addr_t dest_ip,
    output udp_pkg::byte_t      tx_data,
    output logic                tx_valid,
    output logic                tx_last,
    output logic [8:0]          ledg,
    output logic [17:0]         ledr,
    output logic [6:0]          hex0,
    output logic [6:0]          hex1,
    output logic [6:0]          hex2,
    output logic [6:0]          hex3,
    output logic [6:0]          hex4,
    output logic [6:0]          hex5,
    output logic [6:0]          hex6,
    output logic [6:0]          hex7
);
    import udp_pkg::*;
    import panel_pkg::*;

    host_sel_t host_sel;
    logic      start;
    logic      done;
    seg7_t     hex [HEX_DIGITS];

    payload_if stream ();

    assign host_sel = sw[2:1];

    send_ctrl u_send_ctrl (
        .clk      (clk),
        .rst      (rst),
        .btn_send (btn[0]),
        .armed    (sw[0]),
        .host_sel (host_sel),
        .done     (done),
        .start    (start),
        .dest_ip  (dest_ip)
    );

    payload_source u_payload_source (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .done   (done),
        .stream (stream.source)
    );

    front_panel u_front_panel (
        .clk     (clk),
        .rst     (rst),
        .dest_ip (dest_ip),
        .stream  (stream.monitor),
        .ledg    (ledg),
        .hex     (hex)
    );

    // stream to the stack
    assign stream.ready = tx_ready;
    assign tx_data      = stream.data;
    assign tx_valid     = stream.valid;
    assign tx_last      = stream.last;
    assign hdr_valid    = start;

    assign ledr = sw;
    assign hex0 = hex[0];
    assign hex1 = hex[1];
    assign hex2 = hex[2];
    assign hex3 = hex[3];
    assign hex4 = hex[4];
    assign hex5 = hex[5];
    assign hex6 = hex[6];
    assign hex7 = hex[7];

endmodule

`default_nettype wire

// ==== testbench/tb_udp_beacon.sv ====
/*
 * Testbench for the UDP beacon top level. Drives random presses, switch
 * settings and stream back-pressure, and checks every output each cycle
 * against a cycle model of the controller, the stream and the panel.
 */
`timescale 1ns/100ps
`default_nettype none

module tb_udp_beacon;

    localparam int PAYLOAD_LEN    = 18;
    localparam int NUM_FRAMES     = 40;
    // generous per-frame budget over the ~35 cycles a frame really takes
    localparam int FRAME_BUDGET   = 100;
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * FRAME_BUDGET;
    localparam int CTRL_IDLE      = 0;
    localparam int CTRL_BUSY      = 1;
    localparam int CTRL_WAIT      = 2;

    localparam logic [7:0] payload_model [PAYLOAD_LEN] = '{
        8'h41, 8'h42, 8'h43, 8'h44, 8'h45, 8'h46, 8'h47, 8'h48, 8'h49,
        8'h50, 8'h51, 8'h52, 8'h53, 8'h54, 8'h55, 8'h56, 8'h57, 8'h58
    };
    // 192.168.1.100 to .103
    localparam logic [31:0] host_model [4] = '{
        32'hc0a80164, 32'hc0a80165, 32'hc0a80166, 32'hc0a80167
    };
    // active low, segment a in bit 0
    localparam logic [6:0] seg_model [16] = '{
        7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
        7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e
    };

    logic        clk;
    logic        rst;
    logic [3:0]  btn;
    logic [17:0] sw;
    logic        tx_ready;
    logic        ready_high;
    wire         hdr_valid;
    wire  [31:0] dest_ip;
    wire  [7:0]  tx_data;
    wire         tx_valid;
    wire         tx_last;
    wire  [8:0]  ledg;
    wire  [17:0] ledr;
    wire  [6:0]  hex [8];

    // model state
    int          ctrl_state = CTRL_IDLE;
    int          byte_idx = 0;
    logic        exp_hdr = 1'b0;
    logic        exp_valid = 1'b0;
    logic        done_model = 1'b0;
    logic [31:0] exp_dest = '0;
    logic [8:0]  exp_ledg = '0;
    logic        prev_stall = 1'b0;
    logic [7:0]  prev_data = '0;
    logic        prev_last = 1'b0;

    int frames_done = 0;
    int dut_frames = 0;
    int armed_frames = 0;
    int check_count = 0;
    int error_count = 0;
    int cycle_count = 0;

    udp_beacon_top u_dut (
        .clk       (clk),
        .rst       (rst),
        .btn       (btn),
        .sw        (sw),
        .tx_ready  (tx_ready),
        .hdr_valid (hdr_valid),
        .dest_ip   (dest_ip),
        .tx_data   (tx_data),
        .tx_valid  (tx_valid),
        .tx_last   (tx_last),
        .ledg      (ledg),
        .ledr      (ledr),
        .hex0      (hex[0]),
        .hex1      (hex[1]),
        .hex2      (hex[2]),
        .hex3      (hex[3]),
        .hex4      (hex[4]),
        .hex5      (hex[5]),
        .hex6      (hex[6]),
        .hex7      (hex[7])
    );

    always #20 clk = ~clk;

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED at %0t ns: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
        end
    endtask

    // one press; an armed press is held until its frame has gone out
    task automatic run_frame(input logic armed);
        int          start_count;
        int          hold;
        logic [17:0] sw_bits;
        start_count = frames_done;
        sw_bits = 18'($urandom);
        hold = $urandom_range(5, 0);
        @(posedge clk);
        sw  <= {sw_bits[17:1], armed};
        btn <= {3'($urandom), 1'b1};
        if (armed) begin
            while (frames_done == start_count) @(posedge clk);
        end
        repeat (hold + 1) @(posedge clk);
        btn <= 4'b0000;
        repeat (3) @(posedge clk);
    endtask

    // back-pressure, random once the first frames have run with ready high
    always @(posedge clk) begin
        if (ready_high) begin
            tx_ready <= 1'b1;
        end else begin
            tx_ready <= ($urandom % 4) != 0;
        end
    end

    // outputs are stable at the falling edge, inputs show what the next edge samples
    always @(negedge clk) begin : model_check
        int   k;
        logic xfer;
        logic last_xfer;
        if (!rst) begin
            check_value(32'(hdr_valid), 32'(exp_hdr), "hdr_valid");
            check_value(dest_ip, exp_dest, "dest_ip");
            check_value(32'(tx_valid), 32'(exp_valid), "tx_valid");
            check_value(32'(tx_last), 32'(exp_valid && byte_idx == PAYLOAD_LEN - 1),
                        "tx_last");
            if (exp_valid) begin
                check_value(32'(tx_data), 32'(payload_model[byte_idx]), "tx_data");
            end
            if (prev_stall) begin
                check_value(32'(tx_data), 32'(prev_data), "tx_data held in stall");
                check_value(32'(tx_last), 32'(prev_last), "tx_last held in stall");
            end
            check_value(32'(ledg), 32'(exp_ledg), "ledg");
            check_value(32'(ledr), 32'(sw), "ledr");
            for (k = 0; k < 8; k++) begin
                check_value(32'(hex[k]), 32'(seg_model[exp_dest[4*k +: 4]]),
                            $sformatf("hex%0d", k));
            end

            // frames the DUT really ends
            if (tx_valid && tx_ready && tx_last) begin
                dut_frames++;
            end

            // advance the model through the coming edge
            prev_stall = exp_valid && !tx_ready;
            prev_data  = tx_data;
            prev_last  = tx_last;
            xfer       = exp_valid && tx_ready;
            last_xfer  = xfer && (byte_idx == PAYLOAD_LEN - 1);
            if (xfer) begin
                if (byte_idx == 0) begin
                    exp_ledg = {1'b0, payload_model[0]};
                end
                if (last_xfer) begin
                    exp_valid = 1'b0;
                    byte_idx  = 0;
                    frames_done++;
                end else begin
                    byte_idx++;
                end
            end
            if (exp_hdr) begin
                exp_valid = 1'b1;
                byte_idx  = 0;
            end
            exp_hdr = 1'b0;
            case (ctrl_state)
                CTRL_IDLE: begin
                    if (btn[0] && sw[0]) begin
                        exp_hdr    = 1'b1;
                        exp_dest   = host_model[sw[2:1]];
                        ctrl_state = CTRL_BUSY;
                    end
                end
                CTRL_BUSY: begin
                    if (done_model) begin
                        ctrl_state = CTRL_WAIT;
                    end
                end
                default: begin
                    if (!btn[0]) begin
                        ctrl_state = CTRL_IDLE;
                    end
                end
            endcase
            done_model = last_xfer;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin : main
        int   f;
        logic armed;
        void'($urandom(32'h395405f2));
        clk        = 1'b0;
        rst        = 1'b1;
        btn        = '0;
        sw         = '0;
        tx_ready   = 1'b0;
        ready_high = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        for (f = 0; f < NUM_FRAMES; f++) begin
            if (f == 8) begin
                ready_high <= 1'b0;
            end
            // some presses while disarmed
            armed = (f < 4) || (($urandom % 5) != 0);
            if (armed) begin
                armed_frames++;
            end
            run_frame(armed);
        end
        repeat (4) @(posedge clk);
        check_value(32'(dut_frames), 32'(armed_frames), "completed frame count");
        $display("checks %0d, errors %0d, frames %0d of %0d presses",
                 check_count, error_count, dut_frames, NUM_FRAMES);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
design/udp_pkg.sv
design/panel_pkg.sv
design/payload_if.sv
design/seg7_decoder.sv
design/send_ctrl.sv
design/payload_source.sv
design/front_panel.sv
design/udp_beacon_top.sv
testbench/tb_udp_beacon.sv

// ==== Makefile ====
TB_TOP = tb_udp_beacon
LOG    = sim.log

.PHONY: all run lint clean

all: run

obj_dir/sim: list.f design/*.sv testbench/*.sv
	verilator --binary --timing -f list.f --top-module $(TB_TOP) -o sim

run: obj_dir/sim
	./obj_dir/sim | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

lint:
	verilator --lint-only -Wall -f list.f --top-module udp_beacon_top

clean:
	rm -rf obj_dir $(LOG)
